/* compile.f */
+incdir+include
verilog/mem_req_pkg.sv
verilog/dram_cmd_pkg.sv
verilog/req_queue.sv
verilog/bank_tracker.sv
verilog/cmd_sequencer.sv
verilog/dram_array.sv
verilog/mem_subsystem.sv
test/mem_subsystem_tb.sv

/* include/mem_ctrl_cfg.svh */
`ifndef MEM_CTRL_CFG_SVH
`define MEM_CTRL_CFG_SVH

// request side
`define MC_ADDR_W       12
`define MC_DATA_W       16
`define MC_QUEUE_DEPTH  8

// word address split, bank on top, then row, then column
`define MC_BANK_W       2
`define MC_ROW_W        5
`define MC_COL_W        5

// dram timing in clk cycles
`define MC_T_RP         3   // PRE to ACT
`define MC_T_RCD        3   // ACT to RD/WR, must be 2 or more
`define MC_T_CL         4   // RD to data on rd bus

`endif

/* test/mem_subsystem_tb.sv */
`timescale 1ns/1ps
`include "mem_ctrl_cfg.svh"

module mem_subsystem_tb import mem_req_pkg::*; ();

	localparam int WORDS = 1 << `MC_ADDR_W;
	localparam int BUSY_LIMIT = 200;
	localparam int DRAIN_LIMIT = 2000;

	typedef struct packed {
		req_kind_t kind;
		addr_t     addr;
	} stim_t;

	logic clk, rst, in_valid, out_busy, write_done, read_done;
	req_kind_t in_kind;
	addr_t in_addr;
	data_t in_data, data_out;

	stim_t table_q [$];
	data_t exp_q [$]; // read data in acceptance order
	data_t ref_mem [WORDS];
	integer seed;
	int wr_expected, rd_expected, wr_seen, rd_seen;
	logic busy_seen, started;

	mem_subsystem dut0 (
		.clk(clk), .rst(rst), .in_valid(in_valid), .in_kind(in_kind),
		.in_addr(in_addr), .in_data(in_data), .out_busy(out_busy),
		.write_done(write_done), .read_done(read_done), .data_out(data_out)
	);

	always #5 clk = ~clk;

	// bank on top, then row, then column
	function automatic addr_t word_addr(input int bank, input int row, input int col);
		return addr_t'((bank << (`MC_ROW_W + `MC_COL_W)) | (row << `MC_COL_W) | col);
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_data(input data_t got, input data_t exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] data_out got %h expected %h", got, exp));
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
			abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
	endtask

	task automatic add_req(input req_kind_t kind, input int bank, input int row, input int col);
		stim_t s;
		s.kind = kind;
		s.addr = word_addr(bank, row, col);
		table_q.push_back(s);
	endtask

	task automatic build_table();
		add_req(REQ_WRITE, 0, 1, 3); // write then read, row stays open
		add_req(REQ_READ, 0, 1, 3);
		add_req(REQ_WRITE, 1, 2, 5); // row conflict in bank 1
		add_req(REQ_WRITE, 1, 9, 5);
		add_req(REQ_READ, 1, 2, 5);
		add_req(REQ_READ, 1, 9, 5);
		for (int b = 0; b < 4; b++)
			add_req(REQ_WRITE, b, 4, b + 1);
		add_req(REQ_READ, 2, 4, 3); // banks out of order
		add_req(REQ_READ, 0, 4, 1);
		add_req(REQ_READ, 3, 4, 4);
		add_req(REQ_READ, 1, 4, 2);
		// 20 back to back, mostly row misses, fills the queue
		for (int i = 0; i < 10; i++)
			add_req(REQ_WRITE, i % 4, 10 + i, i * 3);
		for (int i = 0; i < 10; i++)
			add_req(REQ_READ, i % 4, 10 + i, i * 3);
		add_req(REQ_WRITE, 2, 7, 30); // overwrite
		add_req(REQ_WRITE, 2, 7, 30);
		add_req(REQ_READ, 2, 7, 30);
	endtask

	// presents one request and holds it until the queue has room
	task automatic send_req(input stim_t s);
		int waited;
		data_t wdata;
		if (s.kind == REQ_WRITE) begin
			wdata = data_t'($random(seed));
			ref_mem[s.addr] = wdata;
			wr_expected++;
		end else begin
			wdata = '0;
			exp_q.push_back(ref_mem[s.addr]);
			rd_expected++;
		end
		started = 1'b1;
		in_valid = 1'b1;
		in_kind = s.kind;
		in_addr = s.addr;
		in_data = wdata;
		waited = 0;
		while (out_busy) begin // in_valid stays high, queue must ignore it
			if (waited == BUSY_LIMIT)
				abort_run("timeout waiting for out_busy to drop");
			@(negedge clk);
			waited++;
		end
		@(negedge clk); // taken on this rising edge
	endtask

	// outputs are settled at the falling edge
	always @(negedge clk) begin
		if (!rst) begin
			if (!started && (out_busy !== 1'b0 || write_done !== 1'b0 || read_done !== 1'b0))
				abort_run("outputs active after reset before the first request");
			if (out_busy === 1'b1)
				busy_seen = 1'b1;
			if (write_done === 1'b1)
				wr_seen++;
			if (read_done === 1'b1) begin
				if (exp_q.size() == 0)
					abort_run("read_done pulsed with no read outstanding");
				check_data(data_out, exp_q.pop_front());
				rd_seen++;
			end
		end
	end

	initial begin
		int waited;
		seed = 32'h0919_da88;
		clk = 1'b0;
		rst = 1'b1;
		in_valid = 1'b0;
		in_kind = REQ_READ;
		in_addr = '0;
		in_data = '0;
		{wr_expected, rd_expected, wr_seen, rd_seen} = '0;
		busy_seen = 1'b0;
		started = 1'b0;
		build_table();
		repeat (16) @(negedge clk);
		rst = 1'b0;
		repeat (4) @(negedge clk); // idle, outputs must stay low
		foreach (table_q[i])
			send_req(table_q[i]);
		in_valid = 1'b0;
		waited = 0;
		while (wr_seen < wr_expected || rd_seen < rd_expected) begin
			if (waited == DRAIN_LIMIT)
				abort_run("timeout waiting for all requests to complete");
			@(negedge clk);
			waited++;
		end
		repeat (10) @(negedge clk); // no stray pulses after the last one
		check_count("write_done count", wr_seen, wr_expected);
		check_count("read_done count", rd_seen, rd_expected);
		if (!busy_seen) begin
			abort_run("out_busy never rose during the back to back burst");
		end else begin
			$display("Testbench passed");
			$finish;
		end
	end

endmodule

/* verilog/bank_tracker.sv */
`timescale 1ns/1ps
`include "mem_ctrl_cfg.svh"

module bank_tracker import mem_req_pkg::*, dram_cmd_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  dram_bus_t  bus,
	input  addr_t      head_addr,
	output row_state_e row_state
);

	localparam int BANKS = 1 << `MC_BANK_W;

	logic [BANKS-1:0] open_flag;
	row_t open_row [BANKS];
	bank_t head_bank;
	row_t head_row;
	logic bus_act;
	logic bus_pre;

	assign head_bank = addr_bank(head_addr);
	assign head_row = addr_row(head_addr);

	assign bus_act = !bus.cs_n && (bus.cmd == CMD_ACT);
	assign bus_pre = !bus.cs_n && (bus.cmd == CMD_PRE);

	always_ff @(posedge clk) begin
		if (rst) begin
			open_flag <= '0; // all banks closed
		end else begin
			if (bus_act)
				open_flag[bus.bank] <= 1'b1;
			else if (bus_pre)
				open_flag[bus.bank] <= 1'b0;
		end
	end

	// row only means something while the flag is set
	always_ff @(posedge clk) begin
		if (bus_act)
			open_row[bus.bank] <= bus.row;
	end

	always_comb begin
		if (!open_flag[head_bank])
			row_state = ROW_CLOSED;
		else if (open_row[head_bank] == head_row)
			row_state = ROW_HIT;
		else
			row_state = ROW_MISS; // other row open, needs PRE first
	end

endmodule

/* verilog/cmd_sequencer.sv */
`timescale 1ns/1ps
`include "mem_ctrl_cfg.svh"

module cmd_sequencer import mem_req_pkg::*, dram_cmd_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  mem_req_t   head,
	input  logic       head_valid,
	input  row_state_e row_state,
	output logic       pop,
	output dram_bus_t  bus,
	output data_t      wr_data,
	input  data_t      rd_data,
	output logic       write_done,
	output logic       read_done,
	output data_t      data_out
);

	localparam int CL = `MC_T_CL;
	localparam int CNT_W = 4;

	typedef enum logic [2:0] {
		IDLE,
		PRECHARGE,
		WAIT_RP,
		ACTIVATE,
		WAIT_RCD,
		ISSUE
	} state_e;

	state_e state;
	state_e state_nxt;
	logic [CNT_W-1:0] wait_cnt;
	logic [CL:0] rd_marks; // one bit per cycle since RD
	logic rd_issue;
	bank_t head_bank;
	row_t head_row;
	col_t head_col;

	assign head_bank = addr_bank(head.addr);
	assign head_row = addr_row(head.addr);
	assign head_col = addr_col(head.addr);

	always_ff @(posedge clk) begin
		if (rst)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (head_valid) begin
					case (row_state)
						ROW_HIT:    state_nxt = ISSUE;
						ROW_CLOSED: state_nxt = ACTIVATE;
						default:    state_nxt = PRECHARGE;
					endcase
				end
			end
			PRECHARGE: state_nxt = WAIT_RP;
			WAIT_RP:   if (wait_cnt == CNT_W'(1)) state_nxt = ACTIVATE;
			ACTIVATE:  state_nxt = WAIT_RCD;
			WAIT_RCD:  if (wait_cnt == CNT_W'(1)) state_nxt = ISSUE;
			ISSUE:     state_nxt = IDLE; // back to idle, the next head gets classified there
			default:   state_nxt = IDLE;
		endcase
	end

	// ACT lands one cycle after the full tRP wait, RD/WR exactly tRCD after ACT
	always_ff @(posedge clk) begin
		if (rst) begin
			wait_cnt <= '0;
		end else begin
			case (state)
				PRECHARGE: wait_cnt <= CNT_W'(`MC_T_RP);
				ACTIVATE:  wait_cnt <= CNT_W'(`MC_T_RCD - 1);
				WAIT_RP,
				WAIT_RCD:  wait_cnt <= wait_cnt - 1'b1;
				default:   wait_cnt <= wait_cnt;
			endcase
		end
	end

	// command per state, address always from the head
	always_comb begin
		bus = '{cs_n: 1'b1, cmd: CMD_NOP, bank: head_bank, row: head_row, col: head_col};
		case (state)
			PRECHARGE: begin
				bus.cs_n = 1'b0;
				bus.cmd = CMD_PRE;
			end
			ACTIVATE: begin
				bus.cs_n = 1'b0;
				bus.cmd = CMD_ACT;
			end
			ISSUE: begin
				bus.cs_n = 1'b0;
				bus.cmd = (head.kind == REQ_WRITE) ? CMD_WR : CMD_RD;
			end
			default: ;
		endcase
	end

	assign pop = (state == ISSUE);
	assign write_done = pop && (head.kind == REQ_WRITE); // write is done once WR goes out
	assign rd_issue = pop && (head.kind == REQ_READ);
	assign wr_data = head.data;

	// read return tracking, several reads may be in flight
	always_ff @(posedge clk) begin
		if (rst)
			rd_marks <= '0;
		else
			rd_marks <= {rd_marks[CL-1:0], rd_issue};
	end

	// rd_data is valid CL cycles after RD, i.e. while rd_marks[CL-1] is set
	always_ff @(posedge clk) begin
		if (rd_marks[CL-1])
			data_out <= rd_data;
	end

	assign read_done = rd_marks[CL];

endmodule

/* verilog/dram_array.sv */
`timescale 1ns/1ps
`include "mem_ctrl_cfg.svh"

module dram_array import mem_req_pkg::*, dram_cmd_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  dram_bus_t bus,
	input  data_t     wr_data,
	output data_t     rd_data
);

	localparam int BANKS = 1 << `MC_BANK_W;
	localparam int WORDS = 1 << `MC_ADDR_W;
	localparam int CL = `MC_T_CL;

	data_t mem [WORDS];
	row_t open_row [BANKS];
	data_t rd_pipe [CL];
	addr_t word_idx;
	logic bus_act;
	logic bus_rd;
	logic bus_wr;

	assign bus_act = !bus.cs_n && (bus.cmd == CMD_ACT);
	assign bus_rd = !bus.cs_n && (bus.cmd == CMD_RD);
	assign bus_wr = !bus.cs_n && (bus.cmd == CMD_WR);

	// RD/WR address the row held open in that bank, not the bus row
	assign word_idx = {bus.bank, open_row[bus.bank], bus.col};

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int b = 0; b < BANKS; b++)
				open_row[b] <= '0;
		end else if (bus_act) begin
			open_row[bus.bank] <= bus.row;
		end
	end

	always_ff @(posedge clk) begin
		if (bus_wr)
			mem[word_idx] <= wr_data;
	end

	// CL deep data pipe, stage 0 loads on RD
	always_ff @(posedge clk) begin
		rd_pipe[0] <= bus_rd ? mem[word_idx] : '0;
		for (int i = 1; i < CL; i++)
			rd_pipe[i] <= rd_pipe[i-1];
	end

	assign rd_data = rd_pipe[CL-1];

endmodule

/* verilog/dram_cmd_pkg.sv */
`include "mem_ctrl_cfg.svh"

package dram_cmd_pkg;

	typedef logic [`MC_BANK_W-1:0] bank_t;
	typedef logic [`MC_ROW_W-1:0]  row_t;
	typedef logic [`MC_COL_W-1:0]  col_t;

	typedef enum logic [2:0] {
		CMD_NOP,
		CMD_ACT,
		CMD_RD,
		CMD_WR,
		CMD_PRE
	} dram_cmd_e;

	// command/address bus, cmd only counts with cs_n low
	typedef struct packed {
		logic      cs_n;
		dram_cmd_e cmd;
		bank_t     bank;
		row_t      row;
		col_t      col;
	} dram_bus_t;

	// head request vs open row of its bank
	typedef enum logic [1:0] {
		ROW_CLOSED,
		ROW_HIT,
		ROW_MISS
	} row_state_e;

	function automatic bank_t addr_bank(input logic [`MC_ADDR_W-1:0] addr);
		return addr[`MC_ADDR_W-1 -: `MC_BANK_W];
	endfunction

	function automatic row_t addr_row(input logic [`MC_ADDR_W-1:0] addr);
		return addr[`MC_COL_W +: `MC_ROW_W];
	endfunction

	function automatic col_t addr_col(input logic [`MC_ADDR_W-1:0] addr);
		return addr[`MC_COL_W-1:0];
	endfunction

endpackage

/* verilog/mem_req_pkg.sv */
`include "mem_ctrl_cfg.svh"

package mem_req_pkg;

	typedef logic [`MC_ADDR_W-1:0] addr_t; // one word per address
	typedef logic [`MC_DATA_W-1:0] data_t;

	// same encoding as in_request_type on the request port
	typedef enum logic {
		REQ_READ  = 1'b0,
		REQ_WRITE = 1'b1
	} req_kind_t;

	// one queued request
	typedef struct packed {
		req_kind_t kind;
		addr_t     addr;
		data_t     data; // don't care for reads
	} mem_req_t;

endpackage

/* verilog/mem_subsystem.sv */
`timescale 1ns/1ps

module mem_subsystem import mem_req_pkg::*, dram_cmd_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      in_valid,
	input  req_kind_t in_kind,
	input  addr_t     in_addr,
	input  data_t     in_data,
	output logic      out_busy,
	output logic      write_done,
	output logic      read_done,
	output data_t     data_out
);

	mem_req_t head;
	logic head_valid;
	logic pop;
	row_state_e row_state;
	dram_bus_t bus; // seen by tracker and array alike
	data_t wr_data;
	data_t rd_data;

	req_queue u_queue (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.in_kind    (in_kind),
		.in_addr    (in_addr),
		.in_data    (in_data),
		.out_busy   (out_busy),
		.head       (head),
		.head_valid (head_valid),
		.pop        (pop)
	);

	bank_tracker u_tracker (
		.clk       (clk),
		.rst       (rst),
		.bus       (bus),
		.head_addr (head.addr),
		.row_state (row_state)
	);

	cmd_sequencer u_seq (
		.clk        (clk),
		.rst        (rst),
		.head       (head),
		.head_valid (head_valid),
		.row_state  (row_state),
		.pop        (pop),
		.bus        (bus),
		.wr_data    (wr_data),
		.rd_data    (rd_data),
		.write_done (write_done),
		.read_done  (read_done),
		.data_out   (data_out)
	);

	dram_array u_dram (
		.clk     (clk),
		.rst     (rst),
		.bus     (bus),
		.wr_data (wr_data),
		.rd_data (rd_data)
	);

endmodule

/* verilog/req_queue.sv */
`timescale 1ns/1ps
`include "mem_ctrl_cfg.svh"

module req_queue import mem_req_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      in_valid,
	input  req_kind_t in_kind,
	input  addr_t     in_addr,
	input  data_t     in_data,
	output logic      out_busy,
	output mem_req_t  head,
	output logic      head_valid,
	input  logic      pop
);

	localparam int DEPTH = `MC_QUEUE_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	mem_req_t entries [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;
	logic push;
	logic do_pop;

	// wrap at DEPTH, depth need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign out_busy = (count == (PTR_W + 1)'(DEPTH)); // full
	assign push = in_valid && !out_busy; // requests while busy are dropped, source holds them
	assign head_valid = (count != '0);
	assign do_pop = pop && head_valid;
	assign head = entries[rd_ptr];

	always_ff @(posedge clk) begin
		if (push)
			entries[wr_ptr] <= '{kind: in_kind, addr: in_addr, data: in_data};
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

endmodule
